//--- src/monopixPkg.sv
`default_nettype none

package monopixPkg;

    // Matrix geometry, scaled down to 8 columns per flavour
    localparam int NumFlavors    = 4;
    localparam int ColsPerFlavor = 8;
    localparam int NumCols       = NumFlavors * ColsPerFlavor;

    localparam int BcidWidth = 6;

    // One bit per flavour: 0 PMOS_NOSF, 1 PMOS, 2 COMP, 3 HV
    typedef logic [NumFlavors-1:0] flavorVecT;

    // Flavour f owns bits 8f to 8f+7
    typedef logic [NumCols-1:0] colVecT;

    typedef logic [BcidWidth-1:0] bcidT;

    // Global configuration word, first shifted bit ends up in EnHitOrOut MSB
    typedef struct packed {
        flavorVecT EnHitOrOut;   // Active low, true hit-OR output
        flavorVecT nEnHitOrOut;  // Active low, complement output
        colVecT    ColPulseSel;  // Columns that receive the injection pulse
        logic      InjMonL;
        logic      InjMonR;
        colVecT    DigMonSel;    // Columns that feed the hit-OR
    } confT;

    localparam int ConfSize = $bits(confT);

    // All hit-OR drivers off, nothing injected or monitored
    localparam confT DefaultConf = '{
        EnHitOrOut:  {NumFlavors{1'b1}},
        nEnHitOrOut: {NumFlavors{1'b1}},
        ColPulseSel: '0,
        InjMonL:     1'b0,
        InjMonR:     1'b0,
        DigMonSel:   '0
    };

endpackage

`default_nettype wire

//--- src/confRegister.sv
`timescale 1ns/1ps
`default_nettype none

module confRegister (
    input  logic              ClkBx,
    input  logic              reset_ff,
    input  logic              ShiftEn,
    input  logic              Si,
    input  logic              Ld,
    input  logic              DefConf,
    output logic              So,
    output monopixPkg::confT  Conf
);

    import monopixPkg::*;

    logic [ConfSize-1:0] shiftReg;

    // Serial chain shifting toward the MSB with Si entering at bit 0
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            shiftReg <= '0;
        end else if (ShiftEn) begin
            shiftReg <= {shiftReg[ConfSize-2:0], Si};
        end
    end

    // Oldest bit in the chain
    assign So = shiftReg[ConfSize-1];

    // Configuration word seen by the periphery
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            Conf <= DefaultConf;
        end else if (DefConf) begin
            Conf <= DefaultConf;   // Default wins over a load in the same cycle
        end else if (Ld) begin
            Conf <= confT'(shiftReg);
        end
    end

    // Shifting goes on while Conf is reloaded
    // A new word can wait in the chain and be applied later

    property confDefaultAfterReset;
        @(posedge ClkBx) reset_ff |=> (Conf == DefaultConf);
    endproperty

    assertConfDefault: assert property (confDefaultAfterReset)
        else $error("Conf not at default after reset");

endmodule

`default_nettype wire

//--- src/bcidCounter.sv
`timescale 1ns/1ps
`default_nettype none

module bcidCounter (
    input  logic              ClkBx,
    input  logic              reset_ff,
    input  logic              ResetBcid,
    output monopixPkg::bcidT  Bcid
);

    import monopixPkg::*;

    logic resetBcidReg;   // ResetBcid delayed by one cycle
    bcidT bcidBin;

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            resetBcidReg <= 1'b0;
        end else begin
            resetBcidReg <= ResetBcid;
        end
    end

    // Free running counter that wraps at 64
    always_ff @(posedge ClkBx) begin
        if (reset_ff || resetBcidReg) begin
            bcidBin <= '0;
        end else begin
            bcidBin <= bcidBin + 1'b1;
        end
    end

    // Gray code so only one bit toggles per crossing
    assign Bcid = bcidBin ^ (bcidBin >> 1);

    property bcidIncrements;
        @(posedge ClkBx) !(reset_ff || resetBcidReg)
            |=> (bcidBin == bcidT'($past(bcidBin) + 1'b1));
    endproperty

    assertIncrement: assert property (bcidIncrements)
        else $error("BCID counter skipped a count");

endmodule

`default_nettype wire

//--- src/columnPeriphery.sv
`timescale 1ns/1ps
`default_nettype none

module columnPeriphery (
    input  monopixPkg::confT       Conf,
    input  logic                   Pulse,
    input  monopixPkg::colVecT     DigMon,
    output monopixPkg::colVecT     InjCol,
    output logic                   InjMonLOut,
    output logic                   InjMonROut,
    output monopixPkg::flavorVecT  HitOrOut,
    output monopixPkg::flavorVecT  HitOrNOut
);

    import monopixPkg::*;

    colVecT    digMonMasked;
    flavorVecT hitOr;

    // Injection fan-out
    assign InjCol     = {NumCols{Pulse}} & Conf.ColPulseSel;
    assign InjMonLOut = Pulse & Conf.InjMonL;   // Left monitor pixel
    assign InjMonROut = Pulse & Conf.InjMonR;   // Right monitor pixel

    // Only selected columns contribute
    assign digMonMasked = DigMon & Conf.DigMonSel;

    // One OR per flavour over its block of columns
    always_comb begin
        hitOr = '0;
        for (int f = 0; f < NumFlavors; f++) begin
            hitOr[f] = |digMonMasked[f*ColsPerFlavor +: ColsPerFlavor];
        end
    end

    // Enables are active low, a disabled output sits at 0
    assign HitOrOut  = hitOr & ~Conf.EnHitOrOut;
    assign HitOrNOut = ~hitOr & ~Conf.nEnHitOrOut;   // Complement driver

    // No column or monitor line may see injection without the pulse
    always_comb begin
        if (!Pulse) begin
            assert #0 ((InjCol == '0) && !InjMonLOut && !InjMonROut)
                else $error("Injection active while Pulse is low");
        end
    end

endmodule

`default_nettype wire

//--- src/monopixTop.sv
`timescale 1ns/1ps
`default_nettype none

module monopixTop (
    input  logic                   ClkBx,
    input  logic                   reset_ff,
    input  logic                   ShiftEn,
    input  logic                   Si,
    input  logic                   Ld,
    input  logic                   DefConf,
    input  logic                   ResetBcid,
    input  logic                   Pulse,
    input  monopixPkg::colVecT     DigMon,
    output logic                   So,
    output logic                   InjMonL,
    output logic                   InjMonR,
    output monopixPkg::bcidT       Bcid,
    output monopixPkg::colVecT     InjCol,
    output monopixPkg::flavorVecT  HitOr,
    output monopixPkg::flavorVecT  HitOrN
);

    import monopixPkg::*;

    confT conf;   // Global configuration to the periphery

    confRegister confRegister_inst (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .ShiftEn  (ShiftEn),
        .Si       (Si),
        .Ld       (Ld),
        .DefConf  (DefConf),
        .So       (So),
        .Conf     (conf)
    );

    bcidCounter bcidCounter_inst (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .ResetBcid (ResetBcid),
        .Bcid      (Bcid)
    );

    // Column monitor bits come straight from the pins
    columnPeriphery columnPeriphery_inst (
        .Conf       (conf),
        .Pulse      (Pulse),
        .DigMon     (DigMon),
        .InjCol     (InjCol),
        .InjMonLOut (InjMonL),
        .InjMonROut (InjMonR),
        .HitOrOut   (HitOr),
        .HitOrNOut  (HitOrN)
    );

endmodule

`default_nettype wire

//--- testbench/tbMonopix.sv
`timescale 1ns/1ps
`default_nettype none

module tbMonopix;

    import monopixPkg::*;

    localparam int BcidTimeout = 8;     // Cycles allowed for the BCID clear
    localparam int MaxCommands = 256;   // Bound on trace commands
    localparam int MaxLineChars = 200;

    logic      ClkBx;
    logic      reset_ff;
    logic      ShiftEn;
    logic      Si;
    logic      Ld;
    logic      DefConf;
    logic      ResetBcid;
    logic      Pulse;
    colVecT    DigMon;
    logic      So;
    logic      InjMonL;
    logic      InjMonR;
    bcidT      Bcid;
    colVecT    InjCol;
    flavorVecT HitOr;
    flavorVecT HitOrN;

    logic [ConfSize-1:0] chainModel;   // Expected shift register contents
    int errorCount;
    int checkCount;

    monopixTop monopixTop_inst (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .ShiftEn   (ShiftEn),
        .Si        (Si),
        .Ld        (Ld),
        .DefConf   (DefConf),
        .ResetBcid (ResetBcid),
        .Pulse     (Pulse),
        .DigMon    (DigMon),
        .So        (So),
        .InjMonL   (InjMonL),
        .InjMonR   (InjMonR),
        .Bcid      (Bcid),
        .InjCol    (InjCol),
        .HitOr     (HitOr),
        .HitOrN    (HitOrN)
    );

    initial begin
        ClkBx = 1'b0;
        forever #2 ClkBx = ~ClkBx;
    end

    task automatic checkValue(input string testName, input logic [63:0] expected,
                              input logic [63:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[FAIL] %s expected %0h actual %0h", testName, expected, actual);
        end
    endtask

    // Each Gray bit is the XOR of two neighbouring binary bits
    function automatic bcidT toGray(input int value);
        bcidT bin;
        bcidT gray;
        bin = bcidT'(value);
        gray[BcidWidth-1] = bin[BcidWidth-1];
        for (int i = 0; i < BcidWidth - 1; i++) begin
            gray[i] = bin[i + 1] ^ bin[i];
        end
        return gray;
    endfunction

    // Back to 1 ns after the next rising edge
    task automatic nextCycle();
        @(posedge ClkBx);
        #1;
    endtask

    // MSB first with So checked against the model before every edge
    task automatic shiftWord(input logic [ConfSize-1:0] word);
        for (int i = ConfSize - 1; i >= 0; i--) begin
            ShiftEn = 1'b1;
            Si      = word[i];
            #1;
            checkValue($sformatf("shift-out bit %0d", i), 64'(chainModel[ConfSize-1]),
                       64'(So));
            nextCycle();
            chainModel = {chainModel[ConfSize-2:0], word[i]};
        end
        ShiftEn = 1'b0;
        Si      = 1'b0;
    endtask

    task automatic loadConf();
        Ld = 1'b1;
        nextCycle();
        Ld = 1'b0;
    endtask

    task automatic applyDefault();
        DefConf = 1'b1;
        nextCycle();
        DefConf = 1'b0;
    endtask

    task automatic setPulse(input logic pulseVal, input colVecT expCol,
                            input logic expMonL, input logic expMonR);
        Pulse = pulseVal;
        #1;
        checkValue("injection columns", 64'(expCol), 64'(InjCol));
        checkValue("injection monitor left", 64'(expMonL), 64'(InjMonL));
        checkValue("injection monitor right", 64'(expMonR), 64'(InjMonR));
        nextCycle();
    endtask

    task automatic setDigMon(input colVecT monBits, input flavorVecT expHitOr,
                             input flavorVecT expHitOrN);
        DigMon = monBits;
        #1;
        checkValue($sformatf("hit-or true, digmon %h", monBits), 64'(expHitOr), 64'(HitOr));
        checkValue($sformatf("hit-or compl, digmon %h", monBits), 64'(expHitOrN), 64'(HitOrN));
        nextCycle();
    endtask

    // One-cycle ResetBcid followed by a Gray count from zero
    task automatic checkBcidRun(input int count);
        int edges;
        ResetBcid = 1'b1;
        edges = 0;
        do begin
            nextCycle();
            edges++;
            ResetBcid = 1'b0;
        end while (!(edges >= 2 && Bcid == toGray(0)) && edges < BcidTimeout);
        if (!(edges >= 2 && Bcid == toGray(0))) begin
            errorCount++;
            $display("Timeout: BCID did not clear within %0d cycles of ResetBcid",
                     BcidTimeout);
        end else begin
            checkValue("bcid reset latency", 64'd2, 64'(edges));
        end
        for (int i = 1; i <= count; i++) begin
            nextCycle();
            checkValue($sformatf("bcid step %0d", i), 64'(toGray(i % 64)), 64'(Bcid));
        end
    endtask

    task automatic runCycles(input int count);
        for (int i = 0; i < count; i++) begin
            nextCycle();
        end
    endtask

    task automatic skipLine(input int fd);
        int ch;
        int n;
        n = 0;
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1 && n < MaxLineChars) begin
            ch = $fgetc(fd);
            n++;
        end
    endtask

    initial begin
        int fd;
        int code;
        int cmdCount;
        byte cmd;
        logic [ConfSize-1:0] opWord;
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] opC;
        logic [31:0] opD;
        reset_ff   = 1'b1;
        ShiftEn    = 1'b0;
        Si         = 1'b0;
        Ld         = 1'b0;
        DefConf    = 1'b0;
        ResetBcid  = 1'b0;
        Pulse      = 1'b1;   // Held high through reset for the reset-state check
        DigMon     = '1;
        chainModel = '0;
        errorCount = 0;
        checkCount = 0;
        cmdCount   = 0;

        repeat (5) @(posedge ClkBx);
        #1;
        reset_ff = 1'b0;

        fd = $fopen("testbench/monopixTrace.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open the trace file testbench/monopixTrace.txt");
        end else begin
            while (cmdCount < MaxCommands) begin
                code = $fscanf(fd, " %c", cmd);
                if (code != 1) break;
                cmdCount++;
                case (cmd)
                    "#": skipLine(fd);
                    "S": begin
                        code = $fscanf(fd, " %h", opWord);
                        shiftWord(opWord);
                    end
                    "L": loadConf();
                    "D": applyDefault();
                    "P": begin
                        code = $fscanf(fd, " %h %h %h %h", opA, opB, opC, opD);
                        setPulse(opA[0], opB, opC[0], opD[0]);
                    end
                    "M": begin
                        code = $fscanf(fd, " %h %h %h", opA, opB, opC);
                        setDigMon(opA, flavorVecT'(opB), flavorVecT'(opC));
                    end
                    "B": begin
                        code = $fscanf(fd, " %h", opA);
                        checkBcidRun(int'(opA));
                    end
                    "R": begin
                        code = $fscanf(fd, " %h", opA);
                        runCycles(int'(opA));
                    end
                    default: begin
                        errorCount++;
                        $display("Unknown trace command '%c', rest of line skipped", cmd);
                        skipLine(fd);
                    end
                endcase
            end
            if (cmdCount >= MaxCommands) begin
                errorCount++;
                $display("Timeout: trace still running after %0d commands", MaxCommands);
            end
            $fclose(fd);
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/monopixTrace.txt
# All operands hex. S word74 | L | D | P pulse injCol monL monR
# M digMon hitOr hitOrN | B cycles (after BCID reset) | R cycles
R 2
P 1 00000000 0 0
M ffffffff 0 0
# Word 1: enables a/6, ColPulseSel 842100ff, monL 1, monR 0, DigMonSel 0f0ff00f
S 29a108403fe0f0ff00f
L
P 1 842100ff 1 0
P 0 00000000 0 0
M 00000000 0 9
M ffffffff 5 0
M 000000f0 0 9
M 00010001 5 8
M 80001000 0 9
M 01000000 0 1
M 00040000 4 9
# Word 2: enables 0/f, ColPulseSel 12345678, monL 0, monR 1, DigMonSel ffffffff
S 03c48d159e1ffffffff
L
P 1 12345678 0 1
M 00000000 0 0
M 00000100 2 0
B 48
D
P 1 00000000 0 0
M ffffffff 0 0
# Word 2 must come out of So intact after the default
S 00000000000000000000
R 4

//--- sim.f
src/monopixPkg.sv
src/confRegister.sv
src/bcidCounter.sv
src/columnPeriphery.sv
src/monopixTop.sv
testbench/tbMonopix.sv

//--- Bender.yml
package:
  name: monopix

sources:
  - src/monopixPkg.sv
  - src/confRegister.sv
  - src/bcidCounter.sv
  - src/columnPeriphery.sv
  - src/monopixTop.sv
  - target: test
    files:
      - testbench/tbMonopix.sv
